// ==== vma_config.svh ====
`ifndef VMA_CONFIG_SVH
`define VMA_CONFIG_SVH

// Address is section then offset, word addressed
`define VMA_SECTION_W 5
`define VMA_OFFSET_W 18

// Full machine word on the AD bus
`define VMA_WORD_W 36

// Microcode magic number field
`define VMA_MAGIC_W 9

// WAIT cycles allowed before a page fail
`define VMA_MEM_TIMEOUT 8

`endif

// ==== vmaPkg.sv ====
`default_nettype none

`include "vma_config.svh"

package vmaPkg;

  typedef logic [`VMA_SECTION_W-1:0] section_t;
  typedef logic [`VMA_OFFSET_W-1:0] offset_t;
  typedef logic [`VMA_SECTION_W+`VMA_OFFSET_W-1:0] vmaAddr_t;
  typedef logic [`VMA_WORD_W-1:0] word_t;
  typedef logic [`VMA_MAGIC_W-1:0] magic_t;

  typedef logic [2:0] vmaOp_t;

  // Memory ops, all load the VMA
  localparam vmaOp_t OP_LOAD_AD = 3'd0;
  localparam vmaOp_t OP_NEXT = 3'd1;
  localparam vmaOp_t OP_MAGIC = 3'd2;
  localparam vmaOp_t OP_INC = 3'd3;
  // Register ops, value 7 does nothing
  localparam vmaOp_t OP_LOAD_PC = 3'd4;
  localparam vmaOp_t OP_LOAD_BRK = 3'd5;
  localparam vmaOp_t OP_LOAD_PREV = 3'd6;

  typedef struct packed {
    vmaOp_t op;
    word_t ad;
    magic_t magic;
  } vmaCmd_t;

  typedef logic [1:0] vmaSel_t;

  localparam vmaSel_t SRC_AD = 2'd0;
  localparam vmaSel_t SRC_PC1 = 2'd1;
  localparam vmaSel_t SRC_MAGIC = 2'd2;
  localparam vmaSel_t SRC_INC = 2'd3;

  typedef struct packed {
    logic loadVma;
    vmaSel_t vmaSrc;
    logic loadPc;
    logic loadBrk;
    logic loadPrev;
    logic loadHeld;
    logic markLocal;
  } regLoad_t;

  typedef struct packed {
    logic acRef;
    logic addrMatch;
    logic vmaSection0;
    logic pcSection0;
  } vmaFlags_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    FINISH,
    FAULT
  } cycleState_t;

endpackage

`default_nettype wire

// ==== vmaAddrGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmaAddrGen (
  input vmaPkg::vmaSel_t src,
  input vmaPkg::word_t ad,
  input vmaPkg::magic_t magic,
  input vmaPkg::vmaAddr_t pc,
  input vmaPkg::vmaAddr_t vma,
  output vmaPkg::vmaAddr_t nextVma
);

  import vmaPkg::*;

  localparam int AddrW = $bits(vmaAddr_t);

  vmaAddr_t base;
  offset_t addend;
  section_t baseSec;
  offset_t baseOff;
  section_t pcSec;

  // Pick base register and increment
  always_comb begin
    base = vma;
    addend = '0;
    case (src)
      SRC_AD: begin
        base = ad[AddrW-1:0];
      end
      SRC_PC1: begin
        base = pc;
        addend = offset_t'(1);
      end
      SRC_MAGIC: begin
        base = pc;
        addend = offset_t'(magic);
      end
      SRC_INC: begin
        base = vma;
        addend = offset_t'(1);
      end
      default: begin
        base = vma;
      end
    endcase
  end

  assign {baseSec, baseOff} = base;

  // Carry out of the offset is dropped, section never changes
  assign nextVma = {baseSec, baseOff + addend};

  assign pcSec = pc[AddrW-1 -: $bits(section_t)];

  // PC-relative forms must stay in the PC section
  always_comb begin
    if (src == SRC_PC1 || src == SRC_MAGIC) begin
      assert (nextVma[AddrW-1 -: $bits(section_t)] == pcSec)
        else $error("nextVma left the PC section");
    end
  end

endmodule

`default_nettype wire

// ==== vmaRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmaRegFile (
  input logic clk,
  input logic reset,
  input vmaPkg::regLoad_t load,
  input vmaPkg::vmaAddr_t nextVma,
  input vmaPkg::word_t ad,
  output vmaPkg::vmaAddr_t vma,
  output vmaPkg::vmaAddr_t pc,
  output vmaPkg::vmaAddr_t held,
  output vmaPkg::vmaAddr_t brk,
  output vmaPkg::section_t prevSec,
  output vmaPkg::vmaFlags_t flags
);

  import vmaPkg::*;

  localparam int AddrW = $bits(vmaAddr_t);
  localparam int SecW = $bits(section_t);
  localparam int OffW = $bits(offset_t);

  // ACs shadow the first sixteen words
  localparam int AcWords = 16;

  logic lastLocal;
  section_t vmaSec;
  section_t pcSec;
  offset_t vmaOff;

  always_ff @(posedge clk) begin
    if (reset) begin
      vma <= '0;
      lastLocal <= 1'b0;
    end else if (load.loadVma) begin
      vma <= nextVma;
      lastLocal <= load.markLocal;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (load.loadPc) begin
      pc <= vma;
    end
  end

  // Snapshot of the address that was acknowledged
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (load.loadHeld) begin
      held <= vma;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      brk <= '0;
      prevSec <= '0;
    end else begin
      if (load.loadBrk) begin
        brk <= ad[AddrW-1:0];
      end
      if (load.loadPrev) begin
        prevSec <= ad[AddrW-1 -: SecW];
      end
    end
  end

  assign vmaSec = vma[AddrW-1 -: SecW];
  assign vmaOff = vma[OffW-1:0];
  assign pcSec = pc[AddrW-1 -: SecW];

  always_comb begin
    flags.vmaSection0 = (vmaSec == '0);
    flags.pcSection0 = (pcSec == '0);
    // Local loads reach the ACs from any section
    flags.acRef = (vmaOff < offset_t'(AcWords)) && (flags.vmaSection0 || lastLocal);
    flags.addrMatch = (vma == brk);
  end

endmodule

`default_nettype wire

// ==== vmaDiagMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmaDiagMux (
  input logic diagRead,
  input logic [2:0] diagSel,
  input vmaPkg::vmaAddr_t vma,
  input vmaPkg::vmaAddr_t pc,
  input vmaPkg::vmaAddr_t held,
  input vmaPkg::vmaAddr_t brk,
  input vmaPkg::section_t prevSec,
  input vmaPkg::vmaFlags_t flags,
  output vmaPkg::word_t diagData
);

  import vmaPkg::*;

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: diagData = word_t'(vma);
        3'd1: diagData = word_t'(pc);
        3'd2: diagData = word_t'(held);
        3'd3: diagData = word_t'(brk);
        3'd4: diagData = word_t'(prevSec);
        // acRef lands in bit 3
        3'd5: diagData = word_t'(flags);
        default: diagData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== refTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vma_config.svh"

module refTimer (
  input logic clk,
  input logic reset,
  input logic start,
  input logic run,
  output logic timeout
);

  localparam int Limit = `VMA_MEM_TIMEOUT;
  localparam int CountW = $clog2(Limit + 1);

  logic [CountW-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= '0;
    end else if (run && !timeout) begin
      count <= count + 1'b1;
    end
  end

  assign timeout = (count == CountW'(Limit));

  assert property (@(posedge clk) disable iff (reset) count <= CountW'(Limit))
    else $error("reference timer ran past its limit");

endmodule

`default_nettype wire

// ==== memCycleFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCycleFsm (
  input logic clk,
  input logic reset,
  input logic cmdStrobe,
  input vmaPkg::vmaCmd_t cmd,
  input logic memAck,
  input logic timeout,
  output vmaPkg::regLoad_t load,
  output logic timerStart,
  output logic timerRun,
  output logic busy,
  output logic memReq,
  output logic done,
  output logic pageFail
);

  import vmaPkg::*;

  cycleState_t state;
  cycleState_t nextState;
  logic accept;
  logic memOp;

  assign accept = cmdStrobe && (state == IDLE);
  assign memOp = cmd.op inside {OP_LOAD_AD, OP_NEXT, OP_MAGIC, OP_INC};

  // Opcode decode into load strobes
  always_comb begin
    load = '0;
    if (accept) begin
      case (cmd.op)
        OP_LOAD_AD: begin
          load.loadVma = 1'b1;
          load.vmaSrc = SRC_AD;
        end
        // Section comes from the PC, so these count as local
        OP_NEXT: begin
          load.loadVma = 1'b1;
          load.vmaSrc = SRC_PC1;
          load.markLocal = 1'b1;
        end
        OP_MAGIC: begin
          load.loadVma = 1'b1;
          load.vmaSrc = SRC_MAGIC;
          load.markLocal = 1'b1;
        end
        OP_INC: begin
          load.loadVma = 1'b1;
          load.vmaSrc = SRC_INC;
        end
        OP_LOAD_PC: load.loadPc = 1'b1;
        OP_LOAD_BRK: load.loadBrk = 1'b1;
        OP_LOAD_PREV: load.loadPrev = 1'b1;
        default: load = '0;
      endcase
    end
    load.loadHeld = (state == WAIT) && memAck;
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = memOp ? WAIT : FINISH;
        end
      end
      // Ack wins over a timeout in the same cycle
      WAIT: begin
        if (memAck) begin
          nextState = FINISH;
        end else if (timeout) begin
          nextState = FAULT;
        end
      end
      FINISH: nextState = IDLE;
      FAULT: nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign timerStart = accept && memOp;
  assign timerRun = (state == WAIT);
  assign busy = (state != IDLE);
  assign memReq = (state == WAIT);
  assign done = (state == FINISH);
  assign pageFail = (state == FAULT);

  assert property (@(posedge clk) disable iff (reset) !(done && pageFail))
    else $error("done and pageFail together");

  assert property (@(posedge clk) disable iff (reset) memReq |-> state == WAIT)
    else $error("memReq outside WAIT");

endmodule

`default_nettype wire

// ==== vmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmaTop (
  input logic clk,
  input logic reset,
  input logic cmdStrobe,
  input vmaPkg::vmaCmd_t cmd,
  input logic memAck,
  input logic diagRead,
  input logic [2:0] diagSel,
  output logic busy,
  output logic done,
  output logic pageFail,
  output logic memReq,
  output vmaPkg::vmaAddr_t memAddr,
  output vmaPkg::vmaFlags_t flags,
  output vmaPkg::word_t diagData
);

  import vmaPkg::*;

  regLoad_t load;
  vmaAddr_t nextVma;
  vmaAddr_t vma;
  vmaAddr_t pc;
  vmaAddr_t held;
  vmaAddr_t brk;
  section_t prevSec;
  logic timerStart;
  logic timerRun;
  logic timeout;

  // Memory address is the VMA itself
  assign memAddr = vma;

  memCycleFsm uFsm (
    .clk(clk),
    .reset(reset),
    .cmdStrobe(cmdStrobe),
    .cmd(cmd),
    .memAck(memAck),
    .timeout(timeout),
    .load(load),
    .timerStart(timerStart),
    .timerRun(timerRun),
    .busy(busy),
    .memReq(memReq),
    .done(done),
    .pageFail(pageFail)
  );

  refTimer uTimer (
    .clk(clk),
    .reset(reset),
    .start(timerStart),
    .run(timerRun),
    .timeout(timeout)
  );

  vmaAddrGen uAddrGen (
    .src(load.vmaSrc),
    .ad(cmd.ad),
    .magic(cmd.magic),
    .pc(pc),
    .vma(vma),
    .nextVma(nextVma)
  );

  vmaRegFile uRegs (
    .clk(clk),
    .reset(reset),
    .load(load),
    .nextVma(nextVma),
    .ad(cmd.ad),
    .vma(vma),
    .pc(pc),
    .held(held),
    .brk(brk),
    .prevSec(prevSec),
    .flags(flags)
  );

  vmaDiagMux uDiag (
    .diagRead(diagRead),
    .diagSel(diagSel),
    .vma(vma),
    .pc(pc),
    .held(held),
    .brk(brk),
    .prevSec(prevSec),
    .flags(flags),
    .diagData(diagData)
  );

endmodule

`default_nettype wire

// ==== tbVmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vma_config.svh"

module tbVmaTop;

  import vmaPkg::*;

  localparam int AddrW = $bits(vmaAddr_t);
  localparam int OffW = $bits(offset_t);
  // Whole test sequence needs under 2000 cycles
  localparam int CycleLimit = 4000;

  logic clk;
  logic reset;
  logic cmdStrobe;
  vmaCmd_t cmd;
  logic memAck;
  logic diagRead;
  logic [2:0] diagSel;
  logic busy;
  logic done;
  logic pageFail;
  logic memReq;
  vmaAddr_t memAddr;
  vmaFlags_t flags;
  word_t diagData;

  // Reference model state
  vmaAddr_t refVma;
  vmaAddr_t refPc;
  vmaAddr_t refHeld;
  vmaAddr_t refBrk;
  section_t refPrev;
  logic refLocal;

  integer seed = 32'haff8;
  int cycleCount = 0;
  int errorCount = 0;
  logic live = 1'b0;
  word_t ad;
  vmaAddr_t addr;

  vmaTop u_dut (
    .clk(clk),
    .reset(reset),
    .cmdStrobe(cmdStrobe),
    .cmd(cmd),
    .memAck(memAck),
    .diagRead(diagRead),
    .diagSel(diagSel),
    .busy(busy),
    .done(done),
    .pageFail(pageFail),
    .memReq(memReq),
    .memAddr(memAddr),
    .flags(flags),
    .diagData(diagData)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic vmaAddr_t refNext(input vmaOp_t cmdOp, input word_t cmdAd,
                                       input magic_t cmdMagic);
    vmaAddr_t base;
    offset_t step;
    offset_t off;
    base = refVma;
    step = '0;
    case (cmdOp)
      OP_LOAD_AD: base = cmdAd[AddrW-1:0];
      OP_NEXT: begin
        base = refPc;
        step = offset_t'(1);
      end
      OP_MAGIC: begin
        base = refPc;
        step = offset_t'(cmdMagic);
      end
      default: step = offset_t'(1);
    endcase
    // Offset wraps, section stays with the base
    off = base[OffW-1:0] + step;
    return {base[AddrW-1:OffW], off};
  endfunction

  function automatic vmaFlags_t refFlags();
    vmaFlags_t f;
    f.vmaSection0 = (refVma[AddrW-1:OffW] == '0);
    f.pcSection0 = (refPc[AddrW-1:OffW] == '0);
    f.acRef = (refVma[OffW-1:0] < offset_t'(16)) && (f.vmaSection0 || refLocal);
    f.addrMatch = (refVma == refBrk);
    return f;
  endfunction

  function automatic word_t refDiag(input logic rd, input logic [2:0] sel);
    word_t w;
    w = '0;
    if (rd) begin
      case (sel)
        3'd0: w = word_t'(refVma);
        3'd1: w = word_t'(refPc);
        3'd2: w = word_t'(refHeld);
        3'd3: w = word_t'(refBrk);
        3'd4: w = word_t'(refPrev);
        3'd5: w = word_t'(refFlags());
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  function automatic word_t randWord();
    return word_t'({$random(seed), $random(seed)});
  endfunction

  function automatic int randDelay();
    return ($random(seed) & 32'h7fffffff) % 6;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Strobe one command and track it in the model at the sampling edge
  task automatic issueCmd(input vmaOp_t cmdOp, input word_t cmdAd, input magic_t cmdMagic);
    @(negedge clk);
    checkValue("busy", busy, 0);
    @(posedge clk);
    cmdStrobe <= 1'b1;
    cmd.op <= cmdOp;
    cmd.ad <= cmdAd;
    cmd.magic <= cmdMagic;
    @(posedge clk);
    cmdStrobe <= 1'b0;
    case (cmdOp)
      OP_LOAD_AD, OP_INC: begin
        refVma = refNext(cmdOp, cmdAd, cmdMagic);
        refLocal = 1'b0;
      end
      OP_NEXT, OP_MAGIC: begin
        refVma = refNext(cmdOp, cmdAd, cmdMagic);
        refLocal = 1'b1;
      end
      OP_LOAD_PC: refPc = refVma;
      OP_LOAD_BRK: refBrk = cmdAd[AddrW-1:0];
      OP_LOAD_PREV: refPrev = cmdAd[AddrW-1:OffW];
      default: ;
    endcase
  endtask

  task automatic runMemRef(input vmaOp_t cmdOp, input word_t cmdAd, input magic_t cmdMagic,
                           input int delay);
    issueCmd(cmdOp, cmdAd, cmdMagic);
    for (int i = 0; i < delay; i++) begin
      @(negedge clk);
      checkValue("memReq", memReq, 1);
      checkValue("memAddr", memAddr, refVma);
      @(posedge clk);
    end
    memAck <= 1'b1;
    @(negedge clk);
    checkValue("memReq", memReq, 1);
    @(posedge clk);
    memAck <= 1'b0;
    refHeld = refVma;
    @(negedge clk);
    checkValue("done", done, 1);
    checkValue("pageFail", pageFail, 0);
    checkValue("memReq", memReq, 0);
    checkValue("busy", busy, 1);
  endtask

  task automatic runRegOp(input vmaOp_t cmdOp, input word_t cmdAd);
    issueCmd(cmdOp, cmdAd, '0);
    @(negedge clk);
    checkValue("done", done, 1);
    checkValue("memReq", memReq, 0);
  endtask

  task automatic runFaultRef(input vmaOp_t cmdOp, input word_t cmdAd, input magic_t cmdMagic);
    int waited;
    logic ended;
    waited = 0;
    ended = 1'b0;
    issueCmd(cmdOp, cmdAd, cmdMagic);
    while (!ended) begin
      @(negedge clk);
      if (done || pageFail) begin
        ended = 1'b1;
      end else begin
        checkValue("memReq", memReq, 1);
        waited++;
      end
    end
    checkValue("pageFail", pageFail, 1);
    checkValue("done", done, 0);
    checkValue("memReq", memReq, 0);
    checkValue("busy", busy, 1);
    // Timer reaches its limit after that many WAIT cycles, then one more to see it
    if (waited != `VMA_MEM_TIMEOUT + 1) begin
      $display("Page fail came after %0d wait cycles instead of %0d", waited,
               `VMA_MEM_TIMEOUT + 1);
      $display("STATUS: FAIL");
      $fatal(1, "Page fail timing wrong");
    end
    // One pulse only
    repeat (3) begin
      @(negedge clk);
      checkValue("pageFail", pageFail, 0);
      checkValue("memReq", memReq, 0);
    end
  endtask

  task automatic checkDiag(input logic [2:0] sel, input word_t exp, input string name);
    @(posedge clk);
    diagRead <= 1'b1;
    diagSel <= sel;
    @(negedge clk);
    checkValue(name, diagData, exp);
    @(posedge clk);
    diagRead <= 1'b0;
    diagSel <= 3'd0;
  endtask

  // Model and DUT compared every cycle
  always @(negedge clk) begin
    if (live) begin
      checkValue("memAddr", memAddr, refVma);
      checkValue("flags", flags, refFlags());
      checkValue("diagData", diagData, refDiag(diagRead, diagSel));
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("STATUS: FAIL");
      $fatal(1, "Run did not finish within %0d cycles", CycleLimit);
    end
  end

  initial begin
    reset = 1'b1;
    cmdStrobe = 1'b0;
    cmd = '0;
    memAck = 1'b0;
    diagRead = 1'b0;
    diagSel = 3'd0;
    refVma = '0;
    refPc = '0;
    refHeld = '0;
    refBrk = '0;
    refPrev = '0;
    refLocal = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    live = 1'b1;
    @(negedge clk);
    checkValue("busy", busy, 0);
    checkValue("done", done, 0);
    checkValue("pageFail", pageFail, 0);
    checkValue("memReq", memReq, 0);

    // All four memory ops from random bases, random ack delay
    for (int i = 0; i < 32; i++) begin
      runMemRef(OP_LOAD_AD, randWord(), '0, randDelay());
      runRegOp(OP_LOAD_PC, '0);
      runMemRef(OP_LOAD_AD, randWord(), '0, randDelay());
      runMemRef(vmaOp_t'(i % 4), randWord(), magic_t'($random(seed)), randDelay());
      checkDiag(3'd2, word_t'(refVma), "held");
    end

    // Offset wrap at the top of section 3
    addr = {5'd3, 18'h3ffff};
    runMemRef(OP_LOAD_AD, word_t'(addr), '0, 0);
    runRegOp(OP_LOAD_PC, '0);
    runMemRef(OP_NEXT, '0, '0, 1);
    @(negedge clk);
    checkValue("memAddr", memAddr, {5'd3, 18'h00000});
    runMemRef(OP_MAGIC, '0, 9'h1ff, 2);
    @(negedge clk);
    checkValue("memAddr", memAddr, {5'd3, 18'h001fe});
    runMemRef(OP_LOAD_AD, word_t'(addr), '0, 0);
    runMemRef(OP_INC, '0, '0, 3);
    @(negedge clk);
    checkValue("memAddr", memAddr, {5'd3, 18'h00000});

    // References that never see an ack
    for (int i = 0; i < 4; i++) begin
      runFaultRef(vmaOp_t'(i), randWord(), magic_t'($random(seed)));
      checkDiag(3'd2, word_t'(refHeld), "held");
    end

    runMemRef(OP_LOAD_AD, randWord(), '0, 1);
    runRegOp(OP_LOAD_PC, '0);
    checkDiag(3'd1, word_t'(refVma), "pc");
    ad = randWord();
    runRegOp(OP_LOAD_BRK, ad);
    checkDiag(3'd3, word_t'(ad[AddrW-1:0]), "brk");
    ad = randWord();
    runRegOp(OP_LOAD_PREV, ad);
    checkDiag(3'd4, word_t'(ad[AddrW-1:OffW]), "prevSec");
    runRegOp(vmaOp_t'(7), randWord());

    // AC references, section 0 and section 7
    runMemRef(OP_LOAD_AD, word_t'({5'd0, 18'd5}), '0, 0);
    @(negedge clk);
    checkValue("acRef", flags.acRef, 1);
    runMemRef(OP_LOAD_AD, word_t'({5'd7, 18'd3}), '0, 0);
    @(negedge clk);
    checkValue("acRef", flags.acRef, 0);
    runRegOp(OP_LOAD_PC, '0);
    runMemRef(OP_NEXT, '0, '0, 0);
    @(negedge clk);
    checkValue("acRef", flags.acRef, 1);
    runMemRef(OP_INC, '0, '0, 0);
    @(negedge clk);
    checkValue("acRef", flags.acRef, 0);
    runMemRef(OP_MAGIC, '0, 9'd20, 0);
    @(negedge clk);
    checkValue("acRef", flags.acRef, 0);
    runRegOp(OP_LOAD_BRK, word_t'(refVma));
    @(negedge clk);
    checkValue("addrMatch", flags.addrMatch, 1);
    runRegOp(OP_LOAD_BRK, word_t'(refVma ^ 23'h1));
    @(negedge clk);
    checkValue("addrMatch", flags.addrMatch, 0);

    // Readback gated by diagRead
    for (int s = 0; s < 8; s++) begin
      @(posedge clk);
      diagSel <= 3'(s);
      @(negedge clk);
      checkValue("diagData", diagData, 0);
    end
    checkDiag(3'd6, '0, "diagData");
    checkDiag(3'd7, '0, "diagData");

    if (errorCount == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "%0d checks failed", errorCount);
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
vmaPkg.sv
vmaAddrGen.sv
vmaRegFile.sv
vmaDiagMux.sv
refTimer.sv
memCycleFsm.sv
vmaTop.sv
tbVmaTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbVmaTop \
  -f verilog.f \
  --Mdir obj_dir \
  -o simv

./obj_dir/simv
